// File: flist.f
+incdir+src
src/mem_bus_pkg.sv
src/cache_pkg.sv
src/icache.sv
src/dcache.sv
src/bus_arbiter.sv
src/mem_subsys.sv
test/mem_subsys_checker.sv
test/tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_mem_subsys -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ns
`include "mem_cfg.svh"

module tb_mem_subsys import mem_bus_pkg::*; ();

   localparam int MEM_WORDS   = 1 << (`MEM_ADDR_W - 2);
   localparam int LINE_COUNT  = 1 << (`MEM_ADDR_W - 4);
   localparam int ACK_TIMEOUT = 200;                 // Cycles per port access

   typedef logic [`MEM_ADDR_W-1:0] addr_t;
   typedef logic [`DATA_W-1:0]     word_t;
   typedef logic [`DATA_W/8-1:0]   strb_t;
   typedef logic [`MEM_ADDR_W-3:0] widx_t;

   logic      clk_i = 1'b0;
   logic      arst_i;
   mem_req_t  i_req;
   mem_resp_t i_resp;
   mem_req_t  d_req;
   mem_resp_t d_resp;
   mem_req_t  mem_req;
   mem_resp_t mem_resp;

   word_t      mem      [MEM_WORDS];                 // Memory behind the bus
   word_t      shadow   [MEM_WORDS];                 // Expected contents
   bit         ifetched [LINE_COUNT];
   bit         stale    [LINE_COUNT];                // Written after an instruction fetch
   mem_req_t   be_reqs   [$];
   arb_grant_e be_grants [$];
   logic [31:0] rng_state = 32'h6f9c_3b04;
   int errors = 0;
   int tests = 0;
   int failed_tests = 0;
   int err_base = 0;
   bit hung = 1'b0;

   always #4 clk_i = ~clk_i;

   mem_subsys dut0 (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .i_req_i   (i_req),
      .i_resp_o  (i_resp),
      .d_req_i   (d_req),
      .d_resp_o  (d_resp),
      .mem_req_o (mem_req),
      .mem_resp_i(mem_resp)
   );

   function automatic word_t lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic clear_bus_log();
      be_reqs.delete();
      be_grants.delete();
   endtask

   // Memory model answering after 1 to 4 cycles
   initial begin : mem_model
      mem_req_t   req_seen;
      arb_grant_e gnt_seen;
      int         lat;
      widx_t      w;
      mem_resp = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[widx_t'(i)]    = lcg_next();
         shadow[widx_t'(i)] = mem[widx_t'(i)];
      end
      forever begin
         @(negedge clk_i);
         if (!arst_i && mem_req.valid) begin
            req_seen = mem_req;
            gnt_seen = dut0.arb0.grant;
            be_reqs.push_back(req_seen);
            be_grants.push_back(gnt_seen);
            lat = 1 + int'(lcg_next() % 32'd4);
            repeat (lat) @(posedge clk_i);
            #1;
            if (mem_req != req_seen || dut0.arb0.grant != gnt_seen) begin
               report_error($sformatf("bus request %h changed owner or fields", req_seen.addr));
            end
            w = req_seen.addr[15:2];
            for (int b = 0; b < `DATA_W/8; b++) begin
               if (req_seen.wstrb[b]) begin
                  mem[w][8*b +: 8] = req_seen.wdata[8*b +: 8];
               end
            end
            mem_resp.rdata = mem[w];
            mem_resp.ack   = 1'b1;
            @(posedge clk_i);
            #1;
            mem_resp = '0;
         end
      end
   end

   // One core access returning cycles from valid to ack
   task automatic port_access(input bit is_d, input addr_t addr, input word_t wdata,
                              input strb_t wstrb, output word_t rdata, output int cycles);
      mem_req_t req;
      bit       got;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      got    = 1'b0;
      cycles = 0;
      rdata  = '0;
      @(posedge clk_i);
      #1;
      if (is_d) d_req = req;
      else i_req = req;
      while (!got && cycles < ACK_TIMEOUT) begin
         @(negedge clk_i);
         if (is_d ? d_resp.ack : i_resp.ack) begin
            got   = 1'b1;
            rdata = is_d ? d_resp.rdata : i_resp.rdata;
         end else begin
            cycles++;
         end
      end
      @(posedge clk_i);
      #1;
      if (is_d) d_req = '0;
      else i_req = '0;
      if (!got) begin
         hung = 1'b1;
         $display("timeout: the %s port ack never came for address %h",
                  is_d ? "data" : "instruction", addr);
      end
   endtask

   task automatic read_check(input bit is_d, input addr_t addr, output int cycles);
      word_t rdata;
      word_t exp;
      exp = shadow[addr[15:2]];
      port_access(is_d, addr, '0, '0, rdata, cycles);
      if (!hung && rdata !== exp) begin
         report_error($sformatf("read %h returned %h, expected %h", addr, rdata, exp));
      end
      if (!is_d) ifetched[addr[15:4]] = 1'b1;
   endtask

   task automatic write_word(input addr_t addr, input word_t wdata, input strb_t wstrb);
      word_t rdata;
      int    cycles;
      for (int b = 0; b < `DATA_W/8; b++) begin
         if (wstrb[b]) shadow[addr[15:2]][8*b +: 8] = wdata[8*b +: 8];
      end
      if (ifetched[addr[15:4]]) stale[addr[15:4]] = 1'b1;   // Icache copy may be old
      port_access(1'b1, addr, wdata, wstrb, rdata, cycles);
      if (!hung && mem[addr[15:2]] !== shadow[addr[15:2]]) begin
         report_error($sformatf("memory at %h is %h after write, expected %h",
                                addr, mem[addr[15:2]], shadow[addr[15:2]]));
      end
   endtask

   task automatic begin_test();
      tests++;
      err_base = errors;
   endtask

   task automatic end_test(input string name);
      if (errors != err_base || hung) begin
         failed_tests++;
         $display("test %s: failed", name);
      end else begin
         $display("test %s: passed", name);
      end
   endtask

   task automatic test_after_reset();
      begin_test();
      repeat (3) begin
         @(negedge clk_i);
         if (i_resp.ack || d_resp.ack || mem_req.valid) begin
            report_error("ack or bus valid active after reset");
         end
      end
      end_test("after_reset");
   endtask

   // Four ordered refill reads then a one-cycle hit
   task automatic miss_then_hit(input bit is_d, input addr_t addr, input string name);
      addr_t      base;
      arb_grant_e want;
      int         cyc;
      begin_test();
      base = {addr[15:4], 4'h0};
      want = is_d ? GRANT_DCACHE : GRANT_ICACHE;
      clear_bus_log();
      read_check(is_d, addr, cyc);
      if (be_reqs.size() != 4) begin
         report_error($sformatf("miss made %0d bus requests, expected 4", be_reqs.size()));
      end else begin
         for (int k = 0; k < 4; k++) begin
            if (be_reqs[k].addr != base + addr_t'(4*k) || be_reqs[k].wstrb != '0 ||
                be_grants[k] != want) begin
               report_error($sformatf("refill request %0d at %h is wrong", k, be_reqs[k].addr));
            end
         end
      end
      clear_bus_log();
      read_check(is_d, addr ^ 16'h0008, cyc);
      if (be_reqs.size() != 0) report_error("hit made bus traffic");
      if (cyc != 1) report_error($sformatf("hit ack after %0d cycles, expected 1", cyc));
      end_test(name);
   endtask

   task automatic test_write_through();
      int cyc;
      begin_test();
      clear_bus_log();
      write_word(16'h0344, 32'ha5c3_1e77, 4'b0101);     // Line cached by the data test
      if (be_reqs.size() != 1) begin
         report_error($sformatf("write made %0d bus requests, expected 1", be_reqs.size()));
      end else if (be_reqs[0].addr != 16'h0344 || be_reqs[0].wstrb != 4'b0101 ||
                   be_reqs[0].wdata != 32'ha5c3_1e77) begin
         report_error("write-through request fields differ from the core write");
      end
      clear_bus_log();
      read_check(1'b1, 16'h0344, cyc);
      if (be_reqs.size() != 0 || cyc != 1) report_error("read after write hit did not hit");
      write_word(16'h0508, 32'h1357_9bdf, 4'hf);       // Uncached line
      clear_bus_log();
      read_check(1'b1, 16'h0508, cyc);
      if (be_reqs.size() != 4) report_error("read after write miss did not refill");
      end_test("write_through");
   endtask

   task automatic test_concurrent();
      int ci;
      int cd;
      int ic_n;
      int dc_n;
      begin_test();
      clear_bus_log();
      fork
         read_check(1'b0, 16'h0664, ci);
         read_check(1'b1, 16'h0788, cd);
      join
      ic_n = 0;
      dc_n = 0;
      foreach (be_reqs[k]) begin
         if (be_grants[k] == GRANT_ICACHE && be_reqs[k].addr[15:4] == 12'h066) ic_n++;
         else if (be_grants[k] == GRANT_DCACHE && be_reqs[k].addr[15:4] == 12'h078) dc_n++;
         else report_error($sformatf("bus request %h has the wrong owner", be_reqs[k].addr));
      end
      if (ic_n != 4 || dc_n != 4) begin
         report_error($sformatf("refills made %0d and %0d requests, expected 4 each", ic_n, dc_n));
      end
      // Both keep requesting, so round robin alternates the owners
      for (int k = 1; k < be_reqs.size(); k++) begin
         if (be_reqs[k].addr[15:4] == be_reqs[k-1].addr[15:4]) begin
            report_error($sformatf("bus request %0d went to the same master twice", k));
         end
      end
      end_test("concurrent_miss");
   endtask

   task automatic test_random();
      word_t r;
      addr_t addr;
      strb_t strb;
      int    cyc;
      begin_test();
      for (int n = 0; n < 48 && !hung; n++) begin
         r    = lcg_next();
         addr = {6'b000010, r[9:2], 2'b00};           // 256 words so lines alias
         strb = (r[23:20] == 4'h0) ? 4'hf : r[23:20];
         case (r[17:16])
            2'd0:    read_check(!stale[addr[15:4]] ? 1'b0 : 1'b1, addr, cyc);
            2'd1:    read_check(1'b1, addr, cyc);
            default: write_word(addr, lcg_next(), strb);
         endcase
      end
      end_test("random");
   endtask

   initial begin
      arst_i = 1'b1;
      i_req  = '0;
      d_req  = '0;
      repeat (3) @(posedge clk_i);
      #1;
      arst_i = 1'b0;
      test_after_reset();
      if (!hung) miss_then_hit(1'b0, 16'h0124, "instr_miss_hit");
      if (!hung) miss_then_hit(1'b1, 16'h0348, "data_miss_hit");
      if (!hung) test_write_through();
      if (!hung) test_concurrent();
      if (!hung) test_random();
      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0 && failed_tests == 0 && !hung) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: test/mem_subsys_checker.sv
`timescale 1ns/1ns

module mem_subsys_checker import mem_bus_pkg::*; (
   input logic      clk_i,
   input logic      arst_i,
   input mem_req_t  i_req_i,
   input mem_resp_t i_resp_i,
   input mem_req_t  d_req_i,
   input mem_resp_t d_resp_i,
   input mem_req_t  mem_req_i,
   input mem_resp_t mem_resp_i
);

   // Core acks only answer a live request
   i_ack_valid: assert property (@(posedge clk_i) disable iff (arst_i)
      i_resp_i.ack |-> i_req_i.valid) else $error("instruction ack without valid");
   d_ack_valid: assert property (@(posedge clk_i) disable iff (arst_i)
      d_resp_i.ack |-> d_req_i.valid) else $error("data ack without valid");

   // Bus request held until its ack
   bus_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_req_i.valid && !mem_resp_i.ack |=> $stable(mem_req_i))
      else $error("bus request changed while waiting for ack");

   // One ack cycle per request
   i_ack_once: assert property (@(posedge clk_i) disable iff (arst_i)
      i_resp_i.ack |=> !i_resp_i.ack) else $error("instruction ack held two cycles");
   d_ack_once: assert property (@(posedge clk_i) disable iff (arst_i)
      d_resp_i.ack |=> !d_resp_i.ack) else $error("data ack held two cycles");

endmodule

bind mem_subsys mem_subsys_checker chk0 (
   .clk_i     (clk_i),
   .arst_i    (arst_i),
   .i_req_i   (i_req_i),
   .i_resp_i  (i_resp_o),
   .d_req_i   (d_req_i),
   .d_resp_i  (d_resp_o),
   .mem_req_i (mem_req_o),
   .mem_resp_i(mem_resp_i)
);

// File: src/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys import mem_bus_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  i_req_i,
   output mem_resp_t i_resp_o,
   input  mem_req_t  d_req_i,
   output mem_resp_t d_resp_o,
   output mem_req_t  mem_req_o,
   input  mem_resp_t mem_resp_i
);

   // Cache back ends toward the arbiter
   mem_req_t  ic_be_req;
   mem_resp_t ic_be_resp;
   mem_req_t  dc_be_req;
   mem_resp_t dc_be_resp;

   icache icache0 (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .req_i    (i_req_i),
      .resp_o   (i_resp_o),
      .be_req_o (ic_be_req),
      .be_resp_i(ic_be_resp)
   );

   dcache dcache0 (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .req_i    (d_req_i),
      .resp_o   (d_resp_o),
      .be_req_o (dc_be_req),
      .be_resp_i(dc_be_resp)
   );

   bus_arbiter arb0 (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .ic_req_i  (ic_be_req),
      .ic_resp_o (ic_be_resp),
      .dc_req_i  (dc_be_req),
      .dc_resp_o (dc_be_resp),
      .mem_req_o (mem_req_o),
      .mem_resp_i(mem_resp_i)
   );

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import mem_bus_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  ic_req_i,
   output mem_resp_t ic_resp_o,
   input  mem_req_t  dc_req_i,
   output mem_resp_t dc_resp_o,
   output mem_req_t  mem_req_o,
   input  mem_resp_t mem_resp_i
);

   arb_grant_e grant_q;
   arb_grant_e grant;
   logic       last_dc_q;   // Data cache was served last

   // New grant decided in the same cycle while idle
   always_comb begin
      grant = grant_q;
      if (grant_q == GRANT_NONE) begin
         if (ic_req_i.valid && dc_req_i.valid) begin
            grant = last_dc_q ? GRANT_ICACHE : GRANT_DCACHE;
         end else if (ic_req_i.valid) begin
            grant = GRANT_ICACHE;
         end else if (dc_req_i.valid) begin
            grant = GRANT_DCACHE;
         end
      end
   end

   // Only the granted side sees the response
   always_comb begin
      mem_req_o = '0;
      ic_resp_o = '0;
      dc_resp_o = '0;
      case (grant)
         GRANT_ICACHE: begin
            mem_req_o = ic_req_i;
            ic_resp_o = mem_resp_i;
         end
         GRANT_DCACHE: begin
            mem_req_o = dc_req_i;
            dc_resp_o = mem_resp_i;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         grant_q   <= GRANT_NONE;
         last_dc_q <= 1'b0;
      end else if (grant != GRANT_NONE) begin
         if (mem_resp_i.ack) begin
            grant_q   <= GRANT_NONE;           // Release after one transaction
            last_dc_q <= (grant == GRANT_DCACHE);
         end else begin
            grant_q <= grant;
         end
      end
   end

endmodule

// File: src/dcache.sv
`timescale 1ns/1ns
`include "mem_cfg.svh"

module dcache import mem_bus_pkg::*, cache_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  req_i,
   output mem_resp_t resp_o,
   output mem_req_t  be_req_o,
   input  mem_resp_t be_resp_i
);

   localparam int LINES = 1 << `DCACHE_LINES_W;
   localparam int WORDS = 1 << `LINE_WORDS_W;

   cache_state_e       state_q;
   word_off_t          word_cnt_q;
   logic               wr_done_q;                // Write-through finished on the bus
   logic [LINES-1:0]   valid_q;
   dc_tag_t            tag_q  [LINES];
   logic [`DATA_W-1:0] data_q [LINES][WORDS];

   dc_tag_t   req_tag;
   dc_index_t req_idx;
   word_off_t req_woff;
   logic      is_write;
   logic      hit;
   logic      refill_last;

   assign req_woff = req_i.addr[`BYTE_OFF_W +: `LINE_WORDS_W];
   assign req_idx  = req_i.addr[`BYTE_OFF_W+`LINE_WORDS_W +: `DCACHE_LINES_W];
   assign req_tag  = req_i.addr[`MEM_ADDR_W-1 -: $bits(dc_tag_t)];
   assign is_write = |req_i.wstrb;
   assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

   assign refill_last = (state_q == ST_REFILL) && be_resp_i.ack && (word_cnt_q == '1);

   // Writes ack only after memory took them
   assign resp_o.ack   = (state_q == ST_LOOKUP) && (is_write ? wr_done_q : hit);
   assign resp_o.rdata = data_q[req_idx][req_woff];

   always_comb begin
      be_req_o = '0;
      case (state_q)
         ST_REFILL: begin
            be_req_o.valid = 1'b1;
            be_req_o.addr  = {req_tag, req_idx, word_cnt_q, {`BYTE_OFF_W{1'b0}}};
         end
         ST_WRITE: begin
            be_req_o       = req_i;                // Same address, data and strobes
            be_req_o.valid = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= ST_IDLE;
         word_cnt_q <= '0;
         wr_done_q  <= 1'b0;
         valid_q    <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_i.valid) begin
                  state_q <= ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               if (is_write) begin
                  if (wr_done_q) begin
                     wr_done_q <= 1'b0;
                     state_q   <= ST_IDLE;
                  end else begin
                     state_q <= ST_WRITE;
                  end
               end else if (hit) begin
                  state_q <= ST_IDLE;
               end else begin
                  state_q    <= ST_REFILL;
                  word_cnt_q <= '0;
               end
            end
            ST_REFILL: begin
               if (be_resp_i.ack) begin
                  word_cnt_q <= word_cnt_q + 1'b1;
               end
               if (refill_last) begin
                  valid_q[req_idx] <= 1'b1;
                  state_q          <= ST_LOOKUP;
               end
            end
            ST_WRITE: begin
               if (be_resp_i.ack) begin
                  wr_done_q <= 1'b1;
                  state_q   <= ST_LOOKUP;        // Core ack next cycle
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Refill fill and byte merge on write hit, a write miss touches nothing
   always_ff @(posedge clk_i) begin
      if ((state_q == ST_REFILL) && be_resp_i.ack) begin
         data_q[req_idx][word_cnt_q] <= be_resp_i.rdata;
      end
      if (refill_last) begin
         tag_q[req_idx] <= req_tag;
      end
      if ((state_q == ST_WRITE) && be_resp_i.ack && hit) begin
         for (int b = 0; b < `DATA_W/8; b++) begin
            if (req_i.wstrb[b]) begin
               data_q[req_idx][req_woff][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: src/icache.sv
`timescale 1ns/1ns
`include "mem_cfg.svh"

module icache import mem_bus_pkg::*, cache_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  req_i,
   output mem_resp_t resp_o,
   output mem_req_t  be_req_o,
   input  mem_resp_t be_resp_i
);

   localparam int LINES = 1 << `ICACHE_LINES_W;
   localparam int WORDS = 1 << `LINE_WORDS_W;

   cache_state_e       state_q;
   word_off_t          word_cnt_q;               // Refill word pointer
   logic [LINES-1:0]   valid_q;
   ic_tag_t            tag_q  [LINES];
   logic [`DATA_W-1:0] data_q [LINES][WORDS];

   ic_tag_t   req_tag;
   ic_index_t req_idx;
   word_off_t req_woff;
   logic      hit;
   logic      refill_last;

   // Core request fields stay stable until ack
   assign req_woff = req_i.addr[`BYTE_OFF_W +: `LINE_WORDS_W];
   assign req_idx  = req_i.addr[`BYTE_OFF_W+`LINE_WORDS_W +: `ICACHE_LINES_W];
   assign req_tag  = req_i.addr[`MEM_ADDR_W-1 -: $bits(ic_tag_t)];
   assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

   assign refill_last = (state_q == ST_REFILL) && be_resp_i.ack && (word_cnt_q == '1);

   // Read-only port, strobes never looked at
   assign resp_o.ack   = (state_q == ST_LOOKUP) && hit;
   assign resp_o.rdata = data_q[req_idx][req_woff];

   // Refill reads in word offset order
   assign be_req_o.valid = (state_q == ST_REFILL);
   assign be_req_o.addr  = {req_tag, req_idx, word_cnt_q, {`BYTE_OFF_W{1'b0}}};
   assign be_req_o.wdata = '0;
   assign be_req_o.wstrb = '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= ST_IDLE;
         word_cnt_q <= '0;
         valid_q    <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_i.valid) begin
                  state_q <= ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               if (hit) begin
                  state_q <= ST_IDLE;            // Ack given this cycle
               end else begin
                  state_q    <= ST_REFILL;
                  word_cnt_q <= '0;
               end
            end
            ST_REFILL: begin
               if (be_resp_i.ack) begin
                  word_cnt_q <= word_cnt_q + 1'b1;
               end
               if (refill_last) begin
                  valid_q[req_idx] <= 1'b1;
                  state_q          <= ST_LOOKUP;  // Answer from the filled line
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Line storage
   always_ff @(posedge clk_i) begin
      if ((state_q == ST_REFILL) && be_resp_i.ack) begin
         data_q[req_idx][word_cnt_q] <= be_resp_i.rdata;
      end
      if (refill_last) begin
         tag_q[req_idx] <= req_tag;
      end
   end

endmodule

// File: src/cache_pkg.sv
`include "mem_cfg.svh"

package cache_pkg;

   // Controller states, shared by both caches
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL,
      ST_WRITE
   } cache_state_e;

   // Word offset inside a line, also the refill counter
   typedef logic [`LINE_WORDS_W-1:0] word_off_t;

   // Instruction cache address fields
   typedef logic [`ICACHE_LINES_W-1:0] ic_index_t;
   typedef logic [`MEM_ADDR_W-`ICACHE_LINES_W-`LINE_WORDS_W-`BYTE_OFF_W-1:0] ic_tag_t;

   // Data cache address fields
   typedef logic [`DCACHE_LINES_W-1:0] dc_index_t;
   typedef logic [`MEM_ADDR_W-`DCACHE_LINES_W-`LINE_WORDS_W-`BYTE_OFF_W-1:0] dc_tag_t;

endpackage

// File: src/mem_bus_pkg.sv
`include "mem_cfg.svh"

package mem_bus_pkg;

   // Master to slave, all strobes zero means read
   typedef struct packed {
      logic                   valid;
      logic [`MEM_ADDR_W-1:0] addr;
      logic [`DATA_W-1:0]     wdata;
      logic [`DATA_W/8-1:0]   wstrb;
   } mem_req_t;

   // Slave to master
   typedef struct packed {
      logic               ack;    // High one cycle per request
      logic [`DATA_W-1:0] rdata;  // Valid with ack on reads
   } mem_resp_t;

   // Owner of the external memory bus
   typedef enum logic [1:0] {
      GRANT_NONE,
      GRANT_ICACHE,
      GRANT_DCACHE
   } arb_grant_e;

endpackage

// File: src/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Byte address width of core ports and memory bus
`define MEM_ADDR_W 16

// Data word width, strobe width is DATA_W/8
`define DATA_W 32

// Byte offset bits inside one word
`define BYTE_OFF_W ($clog2(`DATA_W/8))

// Line geometry, all given as log2
`define LINE_WORDS_W 2      // Four words per line
`define ICACHE_LINES_W 4    // Instruction cache lines
`define DCACHE_LINES_W 4    // Data cache lines

`endif
